// ==== hw/afu.sv ====
`timescale 1ns/1ps
`include "bsp_config.svh"

/*
 * Accelerator top level, APB register access to one memory bank and a reduction kernel
 */
module afu import bsp_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    // Host APB port
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`BSP_APB_ADDR_W-1:0] paddr,
    input  data_t                      pwdata,
    output data_t                      prdata,
    output logic                       pready,
    output logic                       pslverr,
    // Completion interrupt
    output logic                       irq
);

    // Host memory port
    logic      host_we;
    mem_addr_t host_addr;
    data_t     host_wdata;
    data_t     host_rdata;
    // Kernel memory port
    mem_addr_t kern_addr;
    data_t     kern_rdata;
    // Kernel control
    logic      start;
    mem_addr_t base;
    len_t      len;
    logic      busy;
    logic      done;
    data_t     sum;
    data_t     xor_acc;
    // Status path
    logic      launch_err;
    logic      clr_done;
    logic      clr_err;
    logic      irq_en;
    logic      done_flag;
    logic      err_flag;
    data_t     sum_q;
    data_t     xor_q;

    // Register decode
    csr_decode csr_decode_inst (.*);

    // Board memory
    local_mem_bank local_mem_bank_inst (.*);

    // Kernel region
    reduce_kernel reduce_kernel_inst (.*);

    // Result capture
    result_status result_status_inst (.*);

endmodule

// ==== hw/bsp_pkg.sv ====
/*
 * Shared types for the accelerator shell
 */
`include "bsp_config.svh"

package bsp_pkg;

    // One data word
    typedef logic [`BSP_DATA_W-1:0] data_t;

    // Word index into the local memory bank
    typedef logic [`BSP_MEM_ADDR_W-1:0] mem_addr_t;

    // Word count
    // One extra bit so a full-depth range fits
    typedef logic [`BSP_MEM_ADDR_W:0] len_t;

    // Register byte offsets on the APB port
    typedef enum logic [`BSP_APB_ADDR_W-1:0] {
        // Bit 0 write starts the kernel, read gives busy
        CTRL   = 'h00,
        // First word of the launch range
        BASE   = 'h04,
        // Number of words in the launch range
        LEN    = 'h08,
        // Sticky done in bit 0, error in bit 1, write 1 to clear
        STATUS = 'h0C,
        // Read-only results
        SUM    = 'h10,
        XOR    = 'h14,
        // Interrupt enable in bit 0
        IRQ_EN = 'h18
    } csr_off_e;

endpackage

// ==== hw/csr_decode.sv ====
`timescale 1ns/1ps
`include "bsp_config.svh"

/*
 * Host register decode on an APB completer
 * Maps the control registers and the memory window, checks ranges and launches the kernel
 */
module csr_decode import bsp_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    // APB completer
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`BSP_APB_ADDR_W-1:0] paddr,
    input  data_t                      pwdata,
    output data_t                      prdata,
    output logic                       pready,
    output logic                       pslverr,
    // Kernel and result status
    input  logic                       busy,
    input  logic                       done_flag,
    input  logic                       err_flag,
    input  data_t                      sum_q,
    input  data_t                      xor_q,
    // Host port of the local memory
    output logic                       host_we,
    output mem_addr_t                  host_addr,
    output data_t                      host_wdata,
    input  data_t                      host_rdata,
    // Kernel launch and flag control
    output logic                       start,
    output mem_addr_t                  base,
    output len_t                       len,
    output logic                       launch_err,
    output logic                       clr_done,
    output logic                       clr_err,
    output logic                       irq_en
);

    // Window bounds, upper one exclusive
    localparam logic [`BSP_APB_ADDR_W-1:0] WIN_LO = `BSP_APB_ADDR_W'(`BSP_MEM_WINDOW);
    localparam logic [`BSP_APB_ADDR_W-1:0] WIN_HI =
        `BSP_APB_ADDR_W'(`BSP_MEM_WINDOW + 4 * `BSP_MEM_DEPTH);
    // Depth at the width of base plus len
    localparam logic [`BSP_MEM_ADDR_W+1:0] DEPTH_EXT = (`BSP_MEM_ADDR_W+2)'(`BSP_MEM_DEPTH);

    logic                       access;
    logic                       wr_ok;
    logic                       in_window;
    logic [`BSP_APB_ADDR_W-1:0] win_off;
    logic                       reg_hit;
    // SUM and XOR
    logic                       reg_ro;
    // Registers frozen while the kernel runs
    logic                       reg_locked;
    data_t                      reg_rdata;
    logic [`BSP_MEM_ADDR_W+1:0] range_end;
    logic                       range_ok;
    logic                       bus_err;

    // Second phase of a transfer
    assign access    = psel & penable;
    assign in_window = (paddr >= WIN_LO) && (paddr < WIN_HI);
    assign win_off   = paddr - WIN_LO;

    // Register map
    always_comb begin
        reg_hit    = 1'b1;
        reg_ro     = 1'b0;
        reg_locked = 1'b0;
        reg_rdata  = '0;
        case (paddr)
            CTRL: begin
                reg_locked = 1'b1;
                reg_rdata  = data_t'(busy);
            end
            BASE: begin
                reg_locked = 1'b1;
                reg_rdata  = data_t'(base);
            end
            LEN: begin
                reg_locked = 1'b1;
                reg_rdata  = data_t'(len);
            end
            STATUS: reg_rdata = data_t'({err_flag, done_flag});
            SUM: begin
                reg_ro    = 1'b1;
                reg_rdata = sum_q;
            end
            XOR: begin
                reg_ro    = 1'b1;
                reg_rdata = xor_q;
            end
            IRQ_EN: reg_rdata = data_t'(irq_en);
            default: reg_hit = 1'b0;
        endcase
    end

    // Unmapped, write to a locked target while busy, or write to a result
    assign bus_err = !(in_window || reg_hit)
                   || (pwrite && busy && (in_window || reg_locked))
                   || (pwrite && reg_ro);
    assign pslverr = access & bus_err;
    assign pready  = 1'b1;
    assign wr_ok   = access & pwrite & ~bus_err;

    // Window address is stable from setup, so registered read data is ready at access
    assign host_addr  = win_off[`BSP_MEM_ADDR_W+1:2];
    assign host_wdata = pwdata;
    assign host_we    = wr_ok & in_window;
    assign prdata     = in_window ? host_rdata : reg_rdata;

    // Launch range must be non-empty and end inside the bank
    assign range_end = {2'b00, base} + {1'b0, len};
    assign range_ok  = (len != '0) && (range_end <= DEPTH_EXT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            base       <= '0;
            len        <= '0;
            irq_en     <= 1'b0;
            start      <= 1'b0;
            launch_err <= 1'b0;
            clr_done   <= 1'b0;
            clr_err    <= 1'b0;
        end else begin
            // Pulses last one cycle
            start      <= 1'b0;
            launch_err <= 1'b0;
            clr_done   <= 1'b0;
            clr_err    <= 1'b0;
            if (wr_ok) begin
                case (paddr)
                    CTRL: begin
                        if (pwdata[0]) begin
                            start      <= range_ok;
                            launch_err <= !range_ok;
                        end
                    end
                    BASE: base <= pwdata[`BSP_MEM_ADDR_W-1:0];
                    LEN: len <= pwdata[`BSP_MEM_ADDR_W:0];
                    STATUS: begin
                        clr_done <= pwdata[0];
                        clr_err  <= pwdata[1];
                    end
                    IRQ_EN: irq_en <= pwdata[0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hw/local_mem_bank.sv ====
`timescale 1ns/1ps
`include "bsp_config.svh"

/*
 * Local memory bank with a host read/write port and a kernel read port
 */
module local_mem_bank import bsp_pkg::*; (
    input  logic      clk,
    // Host side, write and read
    input  logic      host_we,
    input  mem_addr_t host_addr,
    input  data_t     host_wdata,
    output data_t     host_rdata,
    // Kernel side, read only
    input  mem_addr_t kern_addr,
    output data_t     kern_rdata
);

    // Contents are left as loaded
    data_t mem [`BSP_MEM_DEPTH];

    // Host port
    // Read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        host_rdata <= mem[host_addr];
    end

    // Kernel port
    // One cycle from address to data, no arbitration against the host
    always_ff @(posedge clk) begin
        kern_rdata <= mem[kern_addr];
    end

endmodule

// ==== hw/reduce_kernel.sv ====
`timescale 1ns/1ps
`include "bsp_config.svh"

/*
 * Reduction kernel, streams a word range from local memory
 * Accumulates the wrapping sum and the XOR of the words
 */
module reduce_kernel import bsp_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    // Launch
    input  logic      start,
    input  mem_addr_t base,
    input  len_t      len,
    // Memory read port
    output mem_addr_t kern_addr,
    input  data_t     kern_rdata,
    // Status and results
    output logic      busy,
    output logic      done,
    output data_t     sum,
    output data_t     xor_acc
);

    // Words still to be issued
    len_t remaining;
    // Address goes out this cycle
    logic issue;
    // Read data from last cycle's address is on kern_rdata
    logic rd_vld;
    // Final word arrives this cycle
    logic last;

    assign issue = busy && (remaining != '0);
    // Only the final issue leaves the counter at zero
    assign last  = rd_vld && (remaining == '0);

    // Issue side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            kern_addr <= '0;
            remaining <= '0;
            rd_vld    <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            // Valid trails the issue by the read latency
            rd_vld <= issue;
            done   <= last;
            if (start) begin
                kern_addr <= base;
                remaining <= len;
                busy      <= 1'b1;
            end else begin
                // One address per cycle, several reads in flight
                if (issue) begin
                    kern_addr <= kern_addr + 1'b1;
                    remaining <= remaining - 1'b1;
                end
                // Busy drops as done goes out
                if (last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Accumulate side
    // Cleared on every launch
    always_ff @(posedge clk) begin
        if (start) begin
            sum     <= '0;
            xor_acc <= '0;
        end else if (rd_vld) begin
            sum     <= sum + kern_rdata;
            xor_acc <= xor_acc ^ kern_rdata;
        end
    end

endmodule

// ==== hw/result_status.sv ====
`timescale 1ns/1ps
`include "bsp_config.svh"

/*
 * Result capture, sticky done and error flags, and the interrupt
 */
module result_status import bsp_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    // From the kernel
    input  logic  done,
    input  data_t sum,
    input  data_t xor_acc,
    // From register decode
    input  logic  launch_err,
    input  logic  clr_done,
    input  logic  clr_err,
    input  logic  irq_en,
    // Status back to the host
    output logic  done_flag,
    output logic  err_flag,
    output data_t sum_q,
    output data_t xor_q,
    output logic  irq
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_flag <= 1'b0;
            err_flag  <= 1'b0;
            sum_q     <= '0;
            xor_q     <= '0;
            irq       <= 1'b0;
        end else begin
            // Results held until the next run ends
            if (done) begin
                sum_q <= sum;
                xor_q <= xor_acc;
            end
            // Set beats clear
            if (done) begin
                done_flag <= 1'b1;
            end else if (clr_done) begin
                done_flag <= 1'b0;
            end
            if (launch_err) begin
                err_flag <= 1'b1;
            end else if (clr_err) begin
                err_flag <= 1'b0;
            end
            // Interrupt trails the flag by a cycle
            irq <= done_flag & irq_en;
        end
    end

endmodule

// ==== include/bsp_config.svh ====
/*
 * Build-time sizes for the accelerator shell
 */
`ifndef BSP_CONFIG_SVH
`define BSP_CONFIG_SVH

// Data path

// Kernel and host word width
`define BSP_DATA_W      32

// Local memory bank

// Words in the single bank
`define BSP_MEM_DEPTH   64
// Word index width, log2 of the depth
`define BSP_MEM_ADDR_W  6

// Host MMIO

// APB byte address width
`define BSP_APB_ADDR_W  12
// Start of the memory window
`define BSP_MEM_WINDOW  'h400
// Window spans BSP_MEM_DEPTH words of 4 bytes each
// Registers live below the window

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the accelerator shell testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_afu -f sources.f \
    --Mdir obj_dir -o tb_afu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_afu
if [ $? -ne 0 ]; then
    echo "Simulation reported a failure"
    exit 1
fi

exit 0

// ==== sources.f ====
+incdir+include
hw/bsp_pkg.sv
hw/csr_decode.sv
hw/local_mem_bank.sv
hw/reduce_kernel.sv
hw/result_status.sv
hw/afu.sv
test/tb_afu.sv

// ==== test/tb_afu.sv ====
`timescale 1ns/1ps
`include "bsp_config.svh"

/*
 * Testbench for the accelerator shell
 * Fills the memory over APB, runs reductions and checks flags, interrupt and bus errors
 */
module tb_afu import bsp_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RUNS = 8;
    // Reset, window, reductions, two irq cases, two launch errors, three bus errors
    localparam int NUM_TESTS = 2 + RUNS + 2 + 2 + 3;
    localparam int WATCHDOG_NS = NUM_TESTS * (`BSP_MEM_DEPTH + 40) * CLK_PERIOD;

    logic                       clk;
    logic                       arst_n;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`BSP_APB_ADDR_W-1:0] paddr;
    data_t                      pwdata;
    data_t                      prdata;
    logic                       pready;
    logic                       pslverr;
    logic                       irq;

    // Host-side copy of the memory contents
    data_t model [`BSP_MEM_DEPTH];
    logic [31:0] lcg_state;
    string test_name;

    afu i_dut (.clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .irq(irq));

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Bounds the whole run, including status polling
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    task automatic stop_run(input string why);
        $display("ERROR: %s", why);
        $display("Result: FAILED");
        $fatal(1, "protocol error");
    endtask

    task automatic report_mismatch(input string what, input data_t expected, input data_t actual);
        $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
        $display("Result: FAILED");
        $fatal(1, "value mismatch");
    endtask

    // Completer never stalls
    assert property (@(posedge clk) disable iff (!arst_n) pready)
        else stop_run("pready went low");
    // Error response only inside an access phase
    assert property (@(posedge clk) disable iff (!arst_n) pslverr |-> (psel && penable))
        else stop_run("pslverr raised outside an access phase");

    task automatic check_value(input string what, input data_t expected, input data_t actual);
        assert (actual === expected)
            else report_mismatch(what, expected, actual);
    endtask

    function automatic data_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [`BSP_APB_ADDR_W-1:0] win_addr(input int idx);
        return `BSP_APB_ADDR_W'(`BSP_MEM_WINDOW + 4 * idx);
    endfunction

    // Setup then access, back to back; bus_idle releases the bus
    task automatic apb_xfer(input logic write, input logic [`BSP_APB_ADDR_W-1:0] addr,
                            input data_t wdata, input logic exp_err, output data_t rdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // Sample mid access phase, clear of both edges
        #(CLK_PERIOD/4);
        rdata = prdata;
        check_value("pslverr", data_t'(exp_err), data_t'(pslverr));
    endtask

    task automatic apb_write(input logic [`BSP_APB_ADDR_W-1:0] addr, input data_t wdata,
                             input logic exp_err);
        data_t unused;
        apb_xfer(1'b1, addr, wdata, exp_err, unused);
    endtask

    task automatic apb_read(input logic [`BSP_APB_ADDR_W-1:0] addr, input logic exp_err,
                            output data_t rdata);
        apb_xfer(1'b0, addr, '0, exp_err, rdata);
    endtask

    task automatic bus_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    endtask

    // Poll STATUS until done
    task automatic wait_done();
        data_t st;
        st = '0;
        while (st[0] == 1'b0) apb_read(STATUS, 1'b0, st);
    endtask

    function automatic data_t model_sum(input int first, input int count);
        data_t acc;
        acc = '0;
        for (int i = first; i < first + count; i++) acc = acc + model[i];
        return acc;
    endfunction

    function automatic data_t model_xor(input int first, input int count);
        data_t acc;
        acc = '0;
        for (int i = first; i < first + count; i++) acc = acc ^ model[i];
        return acc;
    endfunction

    task automatic run_reduce(input int first, input int count);
        data_t got;
        apb_write(BASE, data_t'(first), 1'b0);
        apb_write(LEN, data_t'(count), 1'b0);
        apb_write(CTRL, 32'h1, 1'b0);
        wait_done();
        apb_read(SUM, 1'b0, got);
        check_value("sum", model_sum(first, count), got);
        apb_read(XOR, 1'b0, got);
        check_value("xor", model_xor(first, count), got);
        apb_read(CTRL, 1'b0, got);
        check_value("busy after done", 32'h0, got);
    endtask

    // Bad range sets the error flag only
    task automatic launch_error_case(input int first, input int count);
        data_t got;
        apb_write(BASE, data_t'(first), 1'b0);
        apb_write(LEN, data_t'(count), 1'b0);
        apb_write(CTRL, 32'h1, 1'b0);
        apb_read(CTRL, 1'b0, got);
        check_value("busy", 32'h0, got);
        apb_read(STATUS, 1'b0, got);
        check_value("status error set", 32'h2, got);
        apb_write(STATUS, 32'h2, 1'b0);
        apb_read(STATUS, 1'b0, got);
        check_value("status error cleared", 32'h0, got);
    endtask

    initial begin
        data_t got;
        int first;
        int count;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        arst_n      = 1'b0;
        lcg_state   = 32'hd64a_017d;
        test_name   = "reset";
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        check_value("irq", 32'h0, data_t'(irq));
        apb_read(STATUS, 1'b0, got);
        check_value("status", 32'h0, got);
        apb_read(SUM, 1'b0, got);
        check_value("sum", 32'h0, got);
        apb_read(XOR, 1'b0, got);
        check_value("xor", 32'h0, got);
        apb_read(CTRL, 1'b0, got);
        check_value("ctrl", 32'h0, got);

        test_name = "window";
        for (int i = 0; i < `BSP_MEM_DEPTH; i++) begin
            model[i] = lcg_next();
            apb_write(win_addr(i), model[i], 1'b0);
        end
        for (int i = 0; i < `BSP_MEM_DEPTH; i++) begin
            apb_read(win_addr(i), 1'b0, got);
            check_value("readback", model[i], got);
        end

        // Upper LCG bits, the low ones cycle fast
        test_name = "reduce";
        for (int r = 0; r < RUNS; r++) begin
            first = int'((lcg_next() >> 16) % `BSP_MEM_DEPTH);
            count = 1 + int'((lcg_next() >> 16) % (`BSP_MEM_DEPTH - first));
            run_reduce(first, count);
            apb_write(STATUS, 32'h1, 1'b0);
        end

        test_name = "irq enabled";
        apb_write(IRQ_EN, 32'h1, 1'b0);
        run_reduce(0, 16);
        bus_idle(2);
        check_value("irq after done", 32'h1, data_t'(irq));
        apb_write(STATUS, 32'h1, 1'b0);
        bus_idle(3);
        check_value("irq after clear", 32'h0, data_t'(irq));
        apb_read(STATUS, 1'b0, got);
        check_value("status cleared", 32'h0, got);

        test_name = "irq disabled";
        apb_write(IRQ_EN, 32'h0, 1'b0);
        run_reduce(8, 8);
        bus_idle(3);
        check_value("irq masked", 32'h0, data_t'(irq));
        apb_write(STATUS, 32'h1, 1'b0);

        test_name = "launch len zero";
        launch_error_case(3, 0);
        test_name = "launch over depth";
        launch_error_case(`BSP_MEM_DEPTH - 4, 8);

        test_name = "unmapped read";
        apb_read(12'h01C, 1'b1, got);
        test_name = "sum write";
        apb_write(SUM, 32'hdead_beef, 1'b1);

        // Full-depth run, then a window write lands while busy
        test_name = "window write busy";
        apb_write(BASE, 32'h0, 1'b0);
        apb_write(LEN, data_t'(`BSP_MEM_DEPTH), 1'b0);
        apb_write(CTRL, 32'h1, 1'b0);
        apb_write(win_addr(5), ~model[5], 1'b1);
        wait_done();
        apb_read(SUM, 1'b0, got);
        check_value("full sum", model_sum(0, `BSP_MEM_DEPTH), got);
        apb_read(win_addr(5), 1'b0, got);
        check_value("word kept", model[5], got);
        apb_write(STATUS, 32'h1, 1'b0);
        bus_idle(2);

        $display("Result: PASSED");
        $finish;
    end

endmodule
